/* mcu_pkg.sv */
`default_nettype none

package mcu_pkg;

	// bus and table sizes
	localparam int data_w       = 32;
	localparam int table_addr_w = 10; // word address into the data-slot table

	// upper address half of the peripheral page
	localparam logic [15:0] periph_page = 16'hffff;

	// register offsets inside the page, low 16 address bits
	localparam logic [15:0] off_slot_id     = 16'hff80;
	localparam logic [15:0] off_slot_bridge = 16'hff84;
	localparam logic [15:0] off_slot_length = 16'hff88;
	localparam logic [15:0] off_slot_offset = 16'hff8c;
	localparam logic [15:0] off_slot_ctrl   = 16'hff90; // wr: {write, read} pulses, rd: status
	localparam logic [15:0] off_reset_out   = 16'hffa4;
	localparam logic [15:0] off_int_status  = 16'hffb0; // read clears pending
	localparam logic [15:0] off_update_id   = 16'hffb4;
	localparam logic [15:0] off_update_size = 16'hffb8;
	localparam logic [15:0] off_timer       = 16'hffc8; // wr bit 0 clears
	localparam logic [15:0] off_hps_io      = 16'hffd0;

	// clk_sys cycles per millisecond tick, small for simulation
	localparam int ms_prescale = 100;
	localparam int presc_w     = $clog2(ms_prescale);
	localparam logic [presc_w-1:0] presc_last = presc_w'(ms_prescale - 1);

	// one cpu bus request, write when any bytesel bit is set
	typedef struct packed {
		logic [data_w-1:0] addr;
		logic [data_w-1:0] wdata;
		logic [3:0]        bytesel;
	} bus_req_t;

	// decoded access target
	typedef enum logic [3:0] {
		sel_table,
		sel_slot_id,
		sel_slot_bridge,
		sel_slot_length,
		sel_slot_offset,
		sel_slot_ctrl,
		sel_reset_out,
		sel_int_status,
		sel_update_id,
		sel_update_size,
		sel_timer,
		sel_hps_io,
		sel_none
	} periph_sel_e;

	typedef struct packed {
		periph_sel_e             sel;
		logic                    wr;
		logic [data_w-1:0]       wdata;
		logic [table_addr_w-1:0] table_addr;
	} access_t;

	// status back from the data-slot side, read as {ack, done, err}
	typedef struct packed {
		logic       ack;
		logic       done;
		logic [2:0] err;
	} slot_status_t;

	typedef struct packed {
		logic [15:0]       id;
		logic [data_w-1:0] slotoffset;
		logic [data_w-1:0] bridgeaddr;
		logic [data_w-1:0] length;
		logic              read;  // one-cycle pulse
		logic              write; // one-cycle pulse
	} slot_cmd_t;

	// hps parallel port
	typedef struct packed {
		logic [15:0] dout;
		logic        strobe;
		logic        fpga;
		logic        uio;
	} hps_out_t;

	typedef struct packed {
		logic [15:0] din;
		logic        wide;    // 1 = 16 bit, 0 = 8 bit
		logic        io_wait;
	} hps_in_t;

endpackage

`default_nettype wire

/* mcu_bus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module mcu_bus_decode (
	input  wire logic             clk_sys,
	input  wire logic             reset_n,
	input  wire logic             req,
	input  wire logic             ack,
	input  wire mcu_pkg::bus_req_t bus_req,
	output mcu_pkg::access_t      acc,
	output logic                  acc_valid
);

	logic              busy;      // one access in flight
	logic              req_valid; // request latched, not yet classified
	mcu_pkg::bus_req_t req_q;
	logic              accept;

	// map an address onto its target
	function automatic mcu_pkg::periph_sel_e classify(input logic [mcu_pkg::data_w-1:0] addr);
		mcu_pkg::periph_sel_e sel;
		sel = mcu_pkg::sel_none;
		if (addr[31:16] == mcu_pkg::periph_page) begin
			if (addr[15:12] == 4'h0) begin
				sel = mcu_pkg::sel_table; // whole low 4k is the table window
			end else begin
				case (addr[15:0])
					mcu_pkg::off_slot_id:     sel = mcu_pkg::sel_slot_id;
					mcu_pkg::off_slot_bridge: sel = mcu_pkg::sel_slot_bridge;
					mcu_pkg::off_slot_length: sel = mcu_pkg::sel_slot_length;
					mcu_pkg::off_slot_offset: sel = mcu_pkg::sel_slot_offset;
					mcu_pkg::off_slot_ctrl:   sel = mcu_pkg::sel_slot_ctrl;
					mcu_pkg::off_reset_out:   sel = mcu_pkg::sel_reset_out;
					mcu_pkg::off_int_status:  sel = mcu_pkg::sel_int_status;
					mcu_pkg::off_update_id:   sel = mcu_pkg::sel_update_id;
					mcu_pkg::off_update_size: sel = mcu_pkg::sel_update_size;
					mcu_pkg::off_timer:       sel = mcu_pkg::sel_timer;
					mcu_pkg::off_hps_io:      sel = mcu_pkg::sel_hps_io;
					default:                  sel = mcu_pkg::sel_none; // unmapped hole
				endcase
			end
		end
		return sel;
	endfunction

	assign accept = req && !busy; // first edge req is seen

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			busy      <= 1'b0;
			req_valid <= 1'b0;
			acc_valid <= 1'b0;
		end else begin
			if (accept)
				busy <= 1'b1;
			else if (ack)
				busy <= 1'b0; // cpu drops req after this
			req_valid <= accept;
			acc_valid <= req_valid;
		end
	end

	// request payload, then the classified access
	always_ff @(posedge clk_sys) begin
		if (accept)
			req_q <= bus_req;
		if (req_valid) begin
			acc.sel        <= classify(req_q.addr);
			acc.wr         <= |req_q.bytesel;
			acc.wdata      <= req_q.wdata;
			acc.table_addr <= req_q.addr[11:2]; // word address
		end
	end

	// one access pulse per request, ack lands two cycles later
	a_one_access: assert property (@(posedge clk_sys) disable iff (!reset_n)
		acc_valid |=> (!acc_valid ##1 (!acc_valid && ack)));

endmodule

`default_nettype wire

/* mcu_slot_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module mcu_slot_regs (
	input  wire logic                                clk_sys,
	input  wire logic                                reset_n,
	input  wire mcu_pkg::access_t                    acc,
	input  wire logic                                acc_valid,
	input  wire mcu_pkg::slot_status_t               slot_status,
	input  wire logic                                dataslot_update,
	input  wire logic [15:0]                         dataslot_update_id,
	input  wire logic [mcu_pkg::data_w-1:0]          dataslot_update_size,
	output mcu_pkg::slot_cmd_t                       slot_cmd,
	output logic                                     cpu_int,
	output logic                                     reset_out,
	output logic [mcu_pkg::table_addr_w-1:0]         datatable_addr,
	output logic                                     datatable_wren,
	output logic [mcu_pkg::data_w-1:0]               datatable_data,
	input  wire logic [mcu_pkg::data_w-1:0]          datatable_q,
	output logic [mcu_pkg::data_w-1:0]               rd_slot
);

	logic                       wr_acc, rd_acc;
	logic                       int_pending;
	logic [15:0]                upd_id_q;   // id at last update
	logic [mcu_pkg::data_w-1:0] upd_size_q; // size at last update
	logic                       int_rd;

	assign wr_acc = acc_valid && acc.wr;
	assign rd_acc = acc_valid && !acc.wr;
	assign int_rd = rd_acc && (acc.sel == mcu_pkg::sel_int_status);

	// table ram port, ram registers q on the same edge the write lands
	assign datatable_addr = acc.table_addr;
	assign datatable_data = acc.wdata;
	assign datatable_wren = wr_acc && (acc.sel == mcu_pkg::sel_table);

	assign cpu_int = int_pending;

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			slot_cmd   <= '0;
			reset_out  <= 1'b0;
		end else begin
			slot_cmd.read  <= 1'b0; // pulses, default low
			slot_cmd.write <= 1'b0;
			if (wr_acc) begin
				case (acc.sel)
					mcu_pkg::sel_slot_id:     slot_cmd.id         <= acc.wdata[15:0];
					mcu_pkg::sel_slot_bridge: slot_cmd.bridgeaddr <= acc.wdata;
					mcu_pkg::sel_slot_length: slot_cmd.length     <= acc.wdata;
					mcu_pkg::sel_slot_offset: slot_cmd.slotoffset <= acc.wdata;
					mcu_pkg::sel_slot_ctrl:
						{slot_cmd.write, slot_cmd.read} <= acc.wdata[1:0];
					mcu_pkg::sel_reset_out:   reset_out <= acc.wdata[0];
					default: ; // other targets or read-only regs
				endcase
			end
		end
	end

	// update interrupt, a new update beats the clearing read
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			int_pending <= 1'b0;
			upd_id_q    <= '0;
			upd_size_q  <= '0;
		end else if (dataslot_update) begin
			int_pending <= 1'b1;
			upd_id_q    <= dataslot_update_id;
			upd_size_q  <= dataslot_update_size;
		end else if (int_rd) begin
			int_pending <= 1'b0;
		end
	end

	// read word for our own selects, pre-edge values
	always_ff @(posedge clk_sys) begin
		if (rd_acc) begin
			case (acc.sel)
				mcu_pkg::sel_slot_id:     rd_slot <= {16'h0, slot_cmd.id};
				mcu_pkg::sel_slot_bridge: rd_slot <= slot_cmd.bridgeaddr;
				mcu_pkg::sel_slot_length: rd_slot <= slot_cmd.length;
				mcu_pkg::sel_slot_offset: rd_slot <= slot_cmd.slotoffset;
				mcu_pkg::sel_slot_ctrl:   rd_slot <= {27'h0, slot_status}; // {ack, done, err}
				mcu_pkg::sel_reset_out:   rd_slot <= {31'h0, reset_out};
				mcu_pkg::sel_int_status:  rd_slot <= {31'h0, int_pending};
				mcu_pkg::sel_update_id:   rd_slot <= {16'h0, upd_id_q};
				mcu_pkg::sel_update_size: rd_slot <= upd_size_q;
				mcu_pkg::sel_table:       rd_slot <= datatable_q; // unused by return path
				default:                  rd_slot <= '0;
			endcase
		end
	end

	// command pulses never stretch
	a_cmd_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(slot_cmd.read || slot_cmd.write) |=> !(slot_cmd.read || slot_cmd.write));

endmodule

`default_nettype wire

/* mcu_ms_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module mcu_ms_timer (
	input  wire logic                       clk_sys,
	input  wire logic                       reset_n,
	input  wire mcu_pkg::access_t           acc,
	input  wire logic                       acc_valid,
	output logic [mcu_pkg::data_w-1:0]      rd_timer
);

	logic [mcu_pkg::presc_w-1:0] presc;    // cycles inside current ms
	logic [mcu_pkg::data_w-1:0]  ms_count;
	logic                        tick;     // last cycle of a ms
	logic                        clr;
	logic                        timer_hit;

	assign timer_hit = acc_valid && (acc.sel == mcu_pkg::sel_timer);
	assign clr       = timer_hit && acc.wr && acc.wdata[0];
	assign tick      = (presc == mcu_pkg::presc_last);

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			presc    <= '0;
			ms_count <= '0;
		end else if (clr) begin
			presc    <= '0; // clear both together
			ms_count <= '0;
		end else if (tick) begin
			presc    <= '0;
			ms_count <= ms_count + 1'b1;
		end else begin
			presc <= presc + 1'b1;
		end
	end

	// sample includes the edge of the read itself
	always_ff @(posedge clk_sys) begin
		if (timer_hit && !acc.wr)
			rd_timer <= tick ? ms_count + 1'b1 : ms_count;
	end

endmodule

`default_nettype wire

/* mcu_hps_io.sv */
`timescale 1ns/1ps
`default_nettype none

module mcu_hps_io (
	input  wire logic                       clk_sys,
	input  wire logic                       reset_n,
	input  wire mcu_pkg::access_t           acc,
	input  wire logic                       acc_valid,
	input  wire mcu_pkg::hps_in_t           hps_in,
	output mcu_pkg::hps_out_t               hps_out,
	output logic [mcu_pkg::data_w-1:0]      rd_hps
);

	logic        hps_hit;
	logic [15:0] dout_q;
	logic        io_clk;           // cpu driven transfer clock
	logic        io_ss0, io_ss1, io_ss2;
	logic        rack;             // io_clk seen by the far side
	logic        io_ack;

	assign hps_hit = acc_valid && (acc.sel == mcu_pkg::sel_hps_io);

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			dout_q <= '0;
			io_clk <= 1'b0;
			io_ss0 <= 1'b0;
			io_ss1 <= 1'b0;
			io_ss2 <= 1'b0;
		end else if (hps_hit && acc.wr) begin
			dout_q <= acc.wdata[15:0];
			io_clk <= acc.wdata[17];
			io_ss0 <= acc.wdata[18];
			io_ss1 <= acc.wdata[19];
			io_ss2 <= acc.wdata[20];
		end
	end

	// handshake only moves when the far side is not waiting, or mid strobe
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			rack   <= 1'b0;
			io_ack <= 1'b0;
		end else if (!hps_in.io_wait || hps_out.strobe) begin
			rack   <= io_clk;
			io_ack <= rack;
		end
	end

	assign hps_out.dout   = dout_q;
	assign hps_out.strobe = io_clk & ~rack; // high until rack catches up
	assign hps_out.fpga   = io_ss0 & ~io_ss1; // command to fpga
	assign hps_out.uio    = io_ss2 & ~io_ss1; // broadcast

	always_ff @(posedge clk_sys) begin
		if (hps_hit && !acc.wr)
			rd_hps <= {14'h0, io_ack, hps_in.wide, hps_in.din};
	end

	// strobe is a single cycle pulse whatever io_wait does
	a_strobe_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		hps_out.strobe |=> !hps_out.strobe);

endmodule

`default_nettype wire

/* mcu_read_return.sv */
`timescale 1ns/1ps
`default_nettype none

module mcu_read_return (
	input  wire logic                       clk_sys,
	input  wire logic                       reset_n,
	input  wire mcu_pkg::access_t           acc,
	input  wire logic                       acc_valid,
	input  wire logic [mcu_pkg::data_w-1:0] rd_slot,
	input  wire logic [mcu_pkg::data_w-1:0] rd_timer,
	input  wire logic [mcu_pkg::data_w-1:0] rd_hps,
	input  wire logic [mcu_pkg::data_w-1:0] datatable_q,
	output logic                            ack,
	output logic [mcu_pkg::data_w-1:0]      rdata
);

	mcu_pkg::periph_sel_e       sel_q; // lines up with target read words
	logic                       wr_q;
	logic                       valid_q;
	logic [mcu_pkg::data_w-1:0] rd_word;

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			valid_q <= 1'b0;
			ack     <= 1'b0;
		end else begin
			valid_q <= acc_valid;
			ack     <= valid_q; // single cycle by construction
		end
	end

	always_ff @(posedge clk_sys) begin
		if (acc_valid) begin
			sel_q <= acc.sel;
			wr_q  <= acc.wr;
		end
	end

	// pick the target word, writes read back 0
	always_comb begin
		rd_word = '0;
		if (!wr_q) begin
			case (sel_q)
				mcu_pkg::sel_table:       rd_word = datatable_q; // ram answered last edge
				mcu_pkg::sel_slot_id,
				mcu_pkg::sel_slot_bridge,
				mcu_pkg::sel_slot_length,
				mcu_pkg::sel_slot_offset,
				mcu_pkg::sel_slot_ctrl,
				mcu_pkg::sel_reset_out,
				mcu_pkg::sel_int_status,
				mcu_pkg::sel_update_id,
				mcu_pkg::sel_update_size: rd_word = rd_slot;
				mcu_pkg::sel_timer:       rd_word = rd_timer;
				mcu_pkg::sel_hps_io:      rd_word = rd_hps;
				default:                  rd_word = '0; // off page or hole
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (valid_q)
			rdata <= rd_word;
	end

	a_ack_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		ack |=> !ack);

endmodule

`default_nettype wire

/* mcu_periph_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module mcu_periph_bus (
	input  wire logic                               clk_sys,
	input  wire logic                               reset_n,
	// cpu bus
	input  wire mcu_pkg::bus_req_t                  bus_req,
	input  wire logic                               req,
	output logic                                    ack,
	output logic [mcu_pkg::data_w-1:0]              rdata,
	// data-slot table ram
	output logic [mcu_pkg::table_addr_w-1:0]        datatable_addr,
	output logic                                    datatable_wren,
	output logic [mcu_pkg::data_w-1:0]              datatable_data,
	input  wire logic [mcu_pkg::data_w-1:0]         datatable_q,
	// data-slot side
	output mcu_pkg::slot_cmd_t                      slot_cmd,
	input  wire mcu_pkg::slot_status_t              slot_status,
	input  wire logic                               dataslot_update,
	input  wire logic [15:0]                        dataslot_update_id,
	input  wire logic [mcu_pkg::data_w-1:0]         dataslot_update_size,
	output logic                                    cpu_int,
	output logic                                    reset_out,
	// hps port
	output mcu_pkg::hps_out_t                       hps_out,
	input  wire mcu_pkg::hps_in_t                   hps_in
);

	mcu_pkg::access_t           acc;
	logic                       acc_valid;
	logic [mcu_pkg::data_w-1:0] rd_slot;
	logic [mcu_pkg::data_w-1:0] rd_timer;
	logic [mcu_pkg::data_w-1:0] rd_hps;

	mcu_bus_decode i_mcu_bus_decode (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.req       (req),
		.ack       (ack),
		.bus_req   (bus_req),
		.acc       (acc),
		.acc_valid (acc_valid)
	);

	mcu_slot_regs i_mcu_slot_regs (
		.clk_sys              (clk_sys),
		.reset_n              (reset_n),
		.acc                  (acc),
		.acc_valid            (acc_valid),
		.slot_status          (slot_status),
		.dataslot_update      (dataslot_update),
		.dataslot_update_id   (dataslot_update_id),
		.dataslot_update_size (dataslot_update_size),
		.slot_cmd             (slot_cmd),
		.cpu_int              (cpu_int),
		.reset_out            (reset_out),
		.datatable_addr       (datatable_addr),
		.datatable_wren       (datatable_wren),
		.datatable_data       (datatable_data),
		.datatable_q          (datatable_q),
		.rd_slot              (rd_slot)
	);

	mcu_ms_timer i_mcu_ms_timer (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.acc       (acc),
		.acc_valid (acc_valid),
		.rd_timer  (rd_timer)
	);

	mcu_hps_io i_mcu_hps_io (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.acc       (acc),
		.acc_valid (acc_valid),
		.hps_in    (hps_in),
		.hps_out   (hps_out),
		.rd_hps    (rd_hps)
	);

	mcu_read_return i_mcu_read_return (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.acc         (acc),
		.acc_valid   (acc_valid),
		.rd_slot     (rd_slot),
		.rd_timer    (rd_timer),
		.rd_hps      (rd_hps),
		.datatable_q (datatable_q),
		.ack         (ack),
		.rdata       (rdata)
	);

endmodule

`default_nettype wire

/* tb_mcu_model.svh */
`ifndef TB_MCU_MODEL_SVH
`define TB_MCU_MODEL_SVH

// reference state, stepped once per clk_sys edge
mcu_pkg::slot_cmd_t m_cmd;       // slot registers and their pulses
logic               m_reset_out;
logic               m_pending;   // update interrupt
logic [15:0]        m_upd_id;
logic [31:0]        m_upd_size;
int                 m_clear_cyc; // edge of the last timer clear
logic [15:0]        m_dout;
logic               m_io_clk, m_ss0, m_ss1, m_ss2;
logic               m_rack, m_io_ack;
logic [31:0]        m_table [0:1023];
logic [31:0]        m_rdata;     // expected word of the access in flight

task automatic reset_model();
	m_cmd       = '0;
	m_reset_out = 1'b0;
	m_pending   = 1'b0;
	m_upd_id    = '0;
	m_upd_size  = '0;
	m_clear_cyc = 0;
	{m_dout, m_io_clk, m_ss0, m_ss1, m_ss2, m_rack, m_io_ack} = '0;
	m_rdata     = '0;
	for (int i = 0; i < 1024; i++)
		m_table[10'(i)] = table_fill(10'(i)); // same fill as the ram
endtask

function automatic mcu_pkg::hps_out_t expected_hps_out();
	mcu_pkg::hps_out_t o;
	o.dout   = m_dout;
	o.strobe = m_io_clk & ~m_rack;
	o.fpga   = m_ss0 & ~m_ss1;
	o.uio    = m_ss2 & ~m_ss1;
	return o;
endfunction

// one edge; do_acc marks edge 2 of an access
task automatic step_model(input logic do_acc, input mcu_pkg::bus_req_t r, input logic upd,
		input logic [15:0] upd_id, input logic [31:0] upd_size,
		input mcu_pkg::slot_status_t st, input mcu_pkg::hps_in_t hin, input int cyc);
	logic [15:0] off;
	logic        on_page, wr, strobe_pre, int_rd;
	logic [9:0]  taddr;
	off        = r.addr[15:0];
	on_page    = (r.addr[31:16] == mcu_pkg::periph_page);
	wr         = |r.bytesel;
	taddr      = r.addr[11:2];
	strobe_pre = m_io_clk & ~m_rack;
	int_rd     = do_acc && on_page && !wr && (off == mcu_pkg::off_int_status);
	// read word from state before the edge
	if (do_acc) begin
		m_rdata = '0; // writes, holes and off-page
		if (on_page && !wr) begin
			if (off[15:12] == 4'h0) begin
				m_rdata = m_table[taddr];
			end else begin
				case (off)
					mcu_pkg::off_slot_id:     m_rdata = {16'h0, m_cmd.id};
					mcu_pkg::off_slot_bridge: m_rdata = m_cmd.bridgeaddr;
					mcu_pkg::off_slot_length: m_rdata = m_cmd.length;
					mcu_pkg::off_slot_offset: m_rdata = m_cmd.slotoffset;
					mcu_pkg::off_slot_ctrl:   m_rdata = {27'h0, st};
					mcu_pkg::off_reset_out:   m_rdata = {31'h0, m_reset_out};
					mcu_pkg::off_int_status:  m_rdata = {31'h0, m_pending};
					mcu_pkg::off_update_id:   m_rdata = {16'h0, m_upd_id};
					mcu_pkg::off_update_size: m_rdata = m_upd_size;
					mcu_pkg::off_timer:
						m_rdata = 32'((cyc - m_clear_cyc) / mcu_pkg::ms_prescale); // whole ms
					mcu_pkg::off_hps_io:      m_rdata = {14'h0, m_io_ack, hin.wide, hin.din};
					default: ;
				endcase
			end
		end
	end
	m_cmd.read  = 1'b0; // pulses last one cycle
	m_cmd.write = 1'b0;
	if (!hin.io_wait || strobe_pre) begin
		m_io_ack = m_rack; // old rack
		m_rack   = m_io_clk;
	end
	// update beats the clearing read
	if (upd) begin
		m_pending  = 1'b1;
		m_upd_id   = upd_id;
		m_upd_size = upd_size;
	end else if (int_rd) begin
		m_pending = 1'b0;
	end
	if (do_acc && on_page && wr) begin
		if (off[15:12] == 4'h0) begin
			m_table[taddr] = r.wdata; // whole word, bytesel only marks a write
		end else begin
			case (off)
				mcu_pkg::off_slot_id:     m_cmd.id         = r.wdata[15:0];
				mcu_pkg::off_slot_bridge: m_cmd.bridgeaddr = r.wdata;
				mcu_pkg::off_slot_length: m_cmd.length     = r.wdata;
				mcu_pkg::off_slot_offset: m_cmd.slotoffset = r.wdata;
				mcu_pkg::off_slot_ctrl:   {m_cmd.write, m_cmd.read} = r.wdata[1:0];
				mcu_pkg::off_reset_out:   m_reset_out = r.wdata[0];
				mcu_pkg::off_timer:       if (r.wdata[0]) m_clear_cyc = cyc;
				mcu_pkg::off_hps_io: begin
					m_dout   = r.wdata[15:0];
					m_io_clk = r.wdata[17];
					{m_ss2, m_ss1, m_ss0} = r.wdata[20:18];
				end
				default: ; // read-only or hole
			endcase
		end
	end
endtask

`endif

/* tb_mcu_periph_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mcu_periph_bus;

	localparam int n_access = 500;
	localparam logic [15:0] reg_offs [0:10] = '{
		mcu_pkg::off_slot_id, mcu_pkg::off_slot_bridge, mcu_pkg::off_slot_length,
		mcu_pkg::off_slot_offset, mcu_pkg::off_slot_ctrl, mcu_pkg::off_reset_out,
		mcu_pkg::off_int_status, mcu_pkg::off_update_id, mcu_pkg::off_update_size,
		mcu_pkg::off_timer, mcu_pkg::off_hps_io};

	logic                  clk_sys, reset_n;
	mcu_pkg::bus_req_t     bus_req;
	logic                  req, ack;
	logic [31:0]           rdata;
	logic [9:0]            datatable_addr;
	logic                  datatable_wren;
	logic [31:0]           datatable_data, datatable_q;
	mcu_pkg::slot_cmd_t    slot_cmd;
	mcu_pkg::slot_status_t slot_status;
	logic                  dataslot_update;
	logic [15:0]           dataslot_update_id;
	logic [31:0]           dataslot_update_size;
	logic                  cpu_int, reset_out;
	mcu_pkg::hps_out_t     hps_out;
	mcu_pkg::hps_in_t      hps_in;
	logic [31:0]           table_ram [0:1023]; // external data-slot table
	logic [31:0]           rng_state;
	int                    cyc;                // edges since reset release

	mcu_periph_bus i_mcu_periph_bus (.*);

	function automatic logic [31:0] table_fill(input logic [9:0] idx);
		return 32'hb0a5_0000 ^ ({22'h0, idx} * 32'h0001_0421); // odd multiplier, all bits count
	endfunction

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	`include "tb_mcu_model.svh"

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// table ram, q one cycle after the address
	initial begin
		for (int i = 0; i < 1024; i++)
			table_ram[10'(i)] <= table_fill(10'(i));
	end
	always @(posedge clk_sys) begin
		if (datatable_wren)
			table_ram[datatable_addr] <= datatable_data;
		datatable_q <= table_ram[datatable_addr]; // old word on a write
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_rdata(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("** Error at %t: %s expected %h, actual %h", $realtime, name, exp, act);
			abort_run("read data mismatch");
		end
	endtask

	task automatic check_slot_cmd(input mcu_pkg::slot_cmd_t exp, input mcu_pkg::slot_cmd_t act);
		if (act !== exp) begin
			$display("** Error at %t: slot_cmd expected %h, actual %h", $realtime, exp, act);
			abort_run("slot command mismatch");
		end
	endtask

	task automatic check_hps_out(input mcu_pkg::hps_out_t exp, input mcu_pkg::hps_out_t act);
		if (act !== exp) begin
			$display("** Error at %t: hps_out expected %h, actual %h", $realtime, exp, act);
			abort_run("hps port mismatch");
		end
	endtask

	task automatic check_int(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error at %t: %s expected %b, actual %b", $realtime, name, exp, act);
			abort_run("single bit mismatch");
		end
	endtask

	// one clock, model step, per-cycle checks, new side inputs
	task automatic tick(input logic do_acc);
		logic [31:0] rnd, rnd2;
		@(posedge clk_sys);
		#0.5;
		cyc++;
		step_model(do_acc, bus_req, dataslot_update, dataslot_update_id, dataslot_update_size,
			slot_status, hps_in, cyc);
		check_slot_cmd(m_cmd, slot_cmd);
		check_hps_out(expected_hps_out(), hps_out);
		check_int("cpu_int", m_pending, cpu_int);
		check_int("reset_out", m_reset_out, reset_out);
		rnd  = lcg_next();
		rnd2 = lcg_next();
		dataslot_update = (rnd[4:0] == 5'h0); // roughly one in 32
		if (dataslot_update) begin
			dataslot_update_id   = rnd2[15:0];
			dataslot_update_size = lcg_next();
		end
		hps_in.io_wait = (rnd[6:5] != 2'b00); // far side mostly busy
		hps_in.wide    = rnd[7];
		hps_in.din     = rnd[31:16];
		slot_status    = rnd[12:8];
	endtask

	task automatic do_access(input mcu_pkg::bus_req_t r);
		int   n;
		logic got;
		logic tbl_wr;
		n       = 0;
		got     = 1'b0;
		tbl_wr  = (r.addr[31:16] == mcu_pkg::periph_page) && (r.addr[15:12] == 4'h0)
			&& (|r.bytesel);
		bus_req = r;
		req     = 1'b1;
		while (!got && n < 12) begin
			tick(n == 2); // third edge is edge 2 of the access
			n++;
			check_int("datatable_wren", tbl_wr && (n == 2), datatable_wren); // one cycle before edge 2
			if (ack)
				got = 1'b1;
		end
		if (!got)
			abort_run("bus gave no ack within 12 cycles");
		if (n != 4) begin
			$display("** Error at %t: ack latency expected 3, actual %0d", $realtime, n - 1);
			abort_run("ack came in the wrong cycle");
		end
		check_rdata("rdata", m_rdata, rdata);
		req     = 1'b0;
		bus_req = '0;
		tick(1'b0);
		check_int("ack", 1'b0, ack); // single cycle
	endtask

	initial begin
		repeat (n_access * 200 + 16) @(posedge clk_sys);
		abort_run("watchdog expired before the tests finished");
	end

	initial begin
		mcu_pkg::bus_req_t r;
		logic [31:0]       rnd;
		logic [3:0]        kind;
		$timeformat(-9, 1, " ns", 10);
		rng_state            = 32'h75e1_3055;
		cyc                  = 0;
		reset_n              = 1'b0;
		req                  = 1'b0;
		bus_req              = '0;
		slot_status          = '0;
		dataslot_update      = 1'b0;
		dataslot_update_id   = '0;
		dataslot_update_size = '0;
		hps_in               = '0;
		reset_model();
		repeat (16) @(posedge clk_sys);
		#0.5;
		reset_n = 1'b1; // timer counts from the next edge
		for (int i = 0; i < n_access; i++) begin
			rnd     = lcg_next();
			r.wdata = lcg_next();
			kind    = rnd[3:0];
			if (kind < 4'd3)
				r.addr = {mcu_pkg::periph_page, 4'h0, rnd[28] ? rnd[27:16] : {4'h0, rnd[23:16]}};
			else if (kind < 4'd14)
				r.addr = {mcu_pkg::periph_page, reg_offs[kind - 4'd3]};
			else if (kind == 4'd14)
				r.addr = {mcu_pkg::periph_page, rnd[16] ? 16'hff94 : {4'h5, rnd[27:16]}}; // holes
			else
				r.addr = {1'b0, rnd[30:0]}; // off the page
			r.bytesel = rnd[8] ? (rnd[12:9] | 4'h1) : 4'h0;
			do_access(r);
			rnd = lcg_next();
			repeat (1 + int'(rnd[5:0])) tick(1'b0); // idle gap, lets the timer run
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
mcu_pkg.sv
mcu_bus_decode.sv
mcu_slot_regs.sv
mcu_ms_timer.sv
mcu_hps_io.sv
mcu_read_return.sv
mcu_periph_bus.sv
tb_mcu_periph_bus.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the peripheral bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_mcu_periph_bus -f sim.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^=== PASS ===$"; then
	exit 0
fi
exit 1
